/* verilog/decodePkg.sv */
`default_nettype none

package decodePkg;

    // Instruction format, bits 31:30
    localparam logic [1:0] registerFormat = 2'b00;
    localparam logic [1:0] jumpFormat = 2'b01;
    // Any format with this top bit set carries a 16 bit immediate
    localparam logic immediateFormatBit = 1'b1;

    // Category, low two bits of the function field
    localparam logic [1:0] arithmeticCategory = 2'd0;
    localparam logic [1:0] compareCategory = 2'd1;
    localparam logic [1:0] floatCategory = 2'd2;
    localparam logic [1:0] vectorCategory = 2'd3;

    // Memory access
    localparam logic [5:0] loadCode = 6'b111000;
    localparam logic [5:0] loadFloatCode = 6'b111001;
    localparam logic [5:0] storeCode = 6'b111010;
    localparam logic [5:0] storeFloatCode = 6'b111011;

    // Control transfer
    localparam logic [5:0] jumpRegisterCode = 6'b111100;
    localparam logic [5:0] branchZeroCode = 6'b111101;
    localparam logic [5:0] branchNotZeroCode = 6'b111110;
    localparam logic [5:0] jumpLinkCode = 6'b111111;
    localparam logic [5:0] jumpCode = 6'b010000;

    // Immediate into the upper half
    localparam logic [5:0] addUpperCode = 6'b110000;

    // Conversions into the float bank, given as function codes
    localparam logic [5:0] intToFloat = 6'b001110;
    localparam logic [5:0] unsignedToFloat = 6'b001111;

    // Top bit selects the float bank, low five bits the index
    typedef logic [5:0] registerNumber;

    // One 32 bit word, read either as register or as immediate format
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] destination;
            logic [4:0] source1;
            logic [4:0] source2;
            logic [4:0] spare;
            logic [5:0] functionField;
        } registerView;
        struct packed {
            logic [5:0] opcode;
            logic [4:0] destination;
            logic [4:0] source1;
            logic [15:0] immediate;
        } immediateView;
    } instructionWord;

endpackage

`default_nettype wire

/* verilog/instructionDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instructionDecoder (
    input wire Clock,
    input wire reset,
    input wire [31:0] instruction,
    input wire decodeEnable,
    output decodePkg::registerNumber sourceRegister1,
    output decodePkg::registerNumber sourceRegister2,
    output decodePkg::registerNumber destinationRegister,
    output logic [31:0] immediateData,
    output logic immediateActive,
    output logic [5:0] functionCode,
    output logic jumpLink,
    output logic relativeJump,
    output logic absoluteJump,
    output logic loadOp,
    output logic storeOp,
    output logic unconditionalJump,
    output logic conditionalJump,
    output logic jumpOnZero
);

    decodePkg::instructionWord currentInstruction;

    logic [5:0] opcode;
    logic [1:0] format;
    logic [1:0] category;
    logic [5:0] functionField;
    logic [25:0] jumpImmediate;
    logic [15:0] shortImmediate;
    logic isRegisterFormat;
    logic isJumpFormat;
    logic isImmediateFormat;
    logic floatRegisterOp;
    logic floatDestination;

    // Held until the next strobe, zero decodes as a harmless add
    always_ff @(posedge Clock) begin
        if (reset) begin
            currentInstruction <= '0;
        end else if (decodeEnable) begin
            currentInstruction <= instruction;
        end
    end

    assign opcode = currentInstruction.registerView.opcode;
    assign format = opcode[5:4];
    assign functionField = currentInstruction.registerView.functionField;
    assign category = functionField[1:0];
    assign shortImmediate = currentInstruction.immediateView.immediate;

    // Jump offset spans destination, source1 and immediate fields
    assign jumpImmediate = {currentInstruction.immediateView.destination,
                            currentInstruction.immediateView.source1,
                            currentInstruction.immediateView.immediate};

    assign isRegisterFormat = (format == decodePkg::registerFormat);
    assign isJumpFormat = (format == decodePkg::jumpFormat);
    assign isImmediateFormat = (format[1] == decodePkg::immediateFormatBit);
    assign floatRegisterOp = isRegisterFormat && (category == decodePkg::floatCategory);

    assign sourceRegister1 = {floatRegisterOp, currentInstruction.registerView.source1};

    // Stores read their data register from the destination field
    always_comb begin
        if (opcode == decodePkg::storeCode) begin
            sourceRegister2 = {1'b0, currentInstruction.registerView.destination};
        end else if (opcode == decodePkg::storeFloatCode) begin
            sourceRegister2 = {1'b1, currentInstruction.registerView.destination};
        end else begin
            sourceRegister2 = {floatRegisterOp, currentInstruction.registerView.source2};
        end
    end

    assign floatDestination = (opcode == decodePkg::loadFloatCode)
        || (opcode == decodePkg::storeFloatCode)
        || (isRegisterFormat && ((floatRegisterOp && functionField[3:0] < 4'd8)
            || functionField == decodePkg::intToFloat
            || functionField == decodePkg::unsignedToFloat));

    always_comb begin
        if (floatDestination) begin
            destinationRegister = {1'b1, currentInstruction.registerView.destination};
        end else if (isRegisterFormat || isImmediateFormat) begin
            destinationRegister = {1'b0, currentInstruction.registerView.destination};
        end else begin
            // Jumps write nothing
            destinationRegister = '0;
        end
    end

    always_comb begin
        if (isJumpFormat) begin
            immediateData = {{6{jumpImmediate[25]}}, jumpImmediate};
        end else if (opcode == decodePkg::addUpperCode) begin
            immediateData = {shortImmediate, 16'b0};
        end else if (isImmediateFormat) begin
            immediateData = {{16{shortImmediate[15]}}, shortImmediate};
        end else begin
            immediateData = '0;
        end
    end

    assign immediateActive = isJumpFormat || isImmediateFormat;

    // Immediate ALU ops reuse the low opcode bits as function
    always_comb begin
        if (isRegisterFormat) begin
            functionCode = functionField;
        end else if (opcode == decodePkg::addUpperCode || isJumpFormat
                || (opcode >= decodePkg::loadCode && opcode <= decodePkg::jumpLinkCode)) begin
            functionCode = '0;
        end else begin
            functionCode = {1'b0, opcode[4:0]};
        end
    end

    assign jumpLink = (opcode == decodePkg::jumpLinkCode);
    assign relativeJump = (opcode == decodePkg::jumpLinkCode)
        || (opcode == decodePkg::jumpCode)
        || (opcode == decodePkg::branchZeroCode)
        || (opcode == decodePkg::branchNotZeroCode);
    assign absoluteJump = (opcode == decodePkg::jumpRegisterCode);
    assign loadOp = (opcode == decodePkg::loadCode) || (opcode == decodePkg::loadFloatCode);
    assign storeOp = (opcode == decodePkg::storeCode) || (opcode == decodePkg::storeFloatCode);
    assign unconditionalJump = (opcode == decodePkg::jumpRegisterCode)
        || (opcode == decodePkg::jumpLinkCode)
        || (opcode == decodePkg::jumpCode);
    assign conditionalJump = (opcode == decodePkg::branchZeroCode)
        || (opcode == decodePkg::branchNotZeroCode);
    assign jumpOnZero = (opcode == decodePkg::branchZeroCode);

endmodule

`default_nettype wire

/* verilog/registerFile.sv */
`timescale 1ns/10ps
`default_nettype none

module registerFile (
    input wire Clock,
    input wire writeEnable,
    input decodePkg::registerNumber writeRegister,
    input wire [31:0] writeData,
    input decodePkg::registerNumber readRegister1,
    input decodePkg::registerNumber readRegister2,
    output logic [31:0] readData1,
    output logic [31:0] readData2
);

    // Entries 0 to 31 integer bank, 32 to 63 float bank
    logic [31:0] registerArray [64];
    logic writeAllowed;

    // Integer register 0 is hardwired, float register 0 is not
    assign writeAllowed = writeEnable && (writeRegister != '0);

    always_ff @(posedge Clock) begin
        if (writeAllowed) begin
            registerArray[writeRegister] <= writeData;
        end
    end

    // One read port, bypassing a write to the same entry
    function automatic logic [31:0] readPort(
        input decodePkg::registerNumber readRegister,
        input logic bypassValid,
        input decodePkg::registerNumber bypassRegister,
        input logic [31:0] bypassData,
        input logic [31:0] storedData
    );
        logic [31:0] result;
        if (readRegister == '0) begin
            result = '0;
        end else if (bypassValid && bypassRegister == readRegister) begin
            result = bypassData;
        end else begin
            result = storedData;
        end
        return result;
    endfunction

    always_comb begin
        readData1 = readPort(readRegister1, writeAllowed, writeRegister, writeData,
                             registerArray[readRegister1]);
    end

    always_comb begin
        readData2 = readPort(readRegister2, writeAllowed, writeRegister, writeData,
                             registerArray[readRegister2]);
    end

endmodule

`default_nettype wire

/* verilog/operandUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module operandUnit (
    input wire [31:0] pc,
    input wire [31:0] readData1,
    input wire [31:0] readData2,
    input wire [31:0] immediateData,
    input wire immediateActive,
    input wire relativeJump,
    input wire absoluteJump,
    input wire unconditionalJump,
    input wire conditionalJump,
    input wire jumpOnZero,
    output logic [31:0] operandA,
    output logic [31:0] operandB,
    output logic [31:0] storeData,
    output logic [31:0] linkAddress,
    output logic jumpTaken,
    output logic [31:0] jumpTarget
);

    logic sourceIsZero;
    logic conditionMet;

    // ALU inputs
    assign operandA = readData1;

    always_comb begin
        if (immediateActive) begin
            operandB = immediateData;
        end else begin
            operandB = readData2;
        end
    end

    // Stores carry their data on the second read port
    assign storeData = readData2;

    // Return address for jumpLink, the next sequential instruction
    assign linkAddress = pc + 32'd4;

    // Branch condition
    assign sourceIsZero = (readData1 == '0);

    always_comb begin
        if (jumpOnZero) begin
            conditionMet = sourceIsZero;
        end else begin
            conditionMet = !sourceIsZero;
        end
    end

    assign jumpTaken = unconditionalJump || (conditionalJump && conditionMet);

    // Target is also driven for branches not taken
    always_comb begin
        if (relativeJump) begin
            jumpTarget = pc + immediateData;
        end else if (absoluteJump) begin
            jumpTarget = readData1;
        end else begin
            jumpTarget = '0;
        end
    end

endmodule

`default_nettype wire

/* verilog/decodeStage.sv */
`timescale 1ns/10ps
`default_nettype none

module decodeStage (
    input wire Clock,
    input wire reset,
    input wire [31:0] instruction,
    input wire decodeEnable,
    input wire [31:0] pc,
    input wire writeEnable,
    input decodePkg::registerNumber writeRegister,
    input wire [31:0] writeData,
    output logic [31:0] operandA,
    output logic [31:0] operandB,
    output logic [31:0] storeData,
    output logic [31:0] linkAddress,
    output logic jumpTaken,
    output logic [31:0] jumpTarget,
    output decodePkg::registerNumber destinationRegister,
    output logic [5:0] functionCode,
    output logic loadOp,
    output logic storeOp,
    output logic jumpLink
);

    decodePkg::registerNumber sourceRegister1;
    decodePkg::registerNumber sourceRegister2;
    logic [31:0] immediateData;
    logic immediateActive;
    logic relativeJump;
    logic absoluteJump;
    logic unconditionalJump;
    logic conditionalJump;
    logic jumpOnZero;
    logic [31:0] readData1;
    logic [31:0] readData2;

    instructionDecoder instructionDecoder_i (
        .Clock(Clock),
        .reset(reset),
        .instruction(instruction),
        .decodeEnable(decodeEnable),
        .sourceRegister1(sourceRegister1),
        .sourceRegister2(sourceRegister2),
        .destinationRegister(destinationRegister),
        .immediateData(immediateData),
        .immediateActive(immediateActive),
        .functionCode(functionCode),
        .jumpLink(jumpLink),
        .relativeJump(relativeJump),
        .absoluteJump(absoluteJump),
        .loadOp(loadOp),
        .storeOp(storeOp),
        .unconditionalJump(unconditionalJump),
        .conditionalJump(conditionalJump),
        .jumpOnZero(jumpOnZero)
    );

    // Writeback runs independently of decode
    registerFile registerFile_i (
        .Clock(Clock),
        .writeEnable(writeEnable),
        .writeRegister(writeRegister),
        .writeData(writeData),
        .readRegister1(sourceRegister1),
        .readRegister2(sourceRegister2),
        .readData1(readData1),
        .readData2(readData2)
    );

    operandUnit operandUnit_i (
        .pc(pc),
        .readData1(readData1),
        .readData2(readData2),
        .immediateData(immediateData),
        .immediateActive(immediateActive),
        .relativeJump(relativeJump),
        .absoluteJump(absoluteJump),
        .unconditionalJump(unconditionalJump),
        .conditionalJump(conditionalJump),
        .jumpOnZero(jumpOnZero),
        .operandA(operandA),
        .operandB(operandB),
        .storeData(storeData),
        .linkAddress(linkAddress),
        .jumpTaken(jumpTaken),
        .jumpTarget(jumpTarget)
    );

endmodule

`default_nettype wire

/* tb/decodeModel.svh */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

typedef struct packed {
    logic [31:0] operandA;
    logic [31:0] operandB;
    logic [31:0] storeData;
    logic [31:0] linkAddress;
    logic jumpTaken;
    logic [31:0] jumpTarget;
    logic [5:0] destinationRegister;
    logic [5:0] functionCode;
    logic loadOp;
    logic storeOp;
    logic jumpLink;
} stageOutputs;

// Expected stage outputs for one latched instruction
function automatic stageOutputs decodeModel(input logic [31:0] word, input logic [31:0] pcValue,
                                            input logic [31:0] registers [64]);
    stageOutputs result;
    logic [5:0] opcode;
    logic [5:0] func;
    logic registerForm;
    logic jumpForm;
    logic floatOp;
    logic floatDest;
    logic [5:0] source1;
    logic [5:0] source2;
    logic [31:0] immediate;
    logic [31:0] value1;
    logic [31:0] value2;
    opcode = word[31:26];
    func = word[5:0];
    registerForm = (opcode[5:4] == decodePkg::registerFormat);
    jumpForm = (opcode[5:4] == decodePkg::jumpFormat);
    floatOp = registerForm && (func[1:0] == decodePkg::floatCategory);
    source1 = {floatOp, word[20:16]};
    source2 = {floatOp, word[15:11]};
    // Store data comes from the destination field
    if (opcode == decodePkg::storeCode || opcode == decodePkg::storeFloatCode) begin
        source2 = {opcode == decodePkg::storeFloatCode, word[25:21]};
    end
    value1 = (source1 == 6'd0) ? 32'd0 : registers[source1];
    value2 = (source2 == 6'd0) ? 32'd0 : registers[source2];
    floatDest = opcode == decodePkg::loadFloatCode || opcode == decodePkg::storeFloatCode
        || (registerForm && ((floatOp && func[3:0] < 4'd8) || func == decodePkg::intToFloat
            || func == decodePkg::unsignedToFloat));
    if (jumpForm) begin
        immediate = {{6{word[25]}}, word[25:0]};
    end else if (opcode == decodePkg::addUpperCode) begin
        immediate = {word[15:0], 16'd0};
    end else if (opcode[5]) begin
        immediate = {{16{word[15]}}, word[15:0]};
    end else begin
        immediate = 32'd0;
    end
    result.destinationRegister = floatDest ? {1'b1, word[25:21]}
        : (jumpForm ? 6'd0 : {1'b0, word[25:21]});
    if (registerForm) begin
        result.functionCode = func;
    end else if (opcode == decodePkg::addUpperCode || jumpForm
            || (opcode >= decodePkg::loadCode && opcode <= decodePkg::jumpLinkCode)) begin
        result.functionCode = 6'd0;
    end else begin
        result.functionCode = {1'b0, opcode[4:0]};
    end
    result.loadOp = opcode == decodePkg::loadCode || opcode == decodePkg::loadFloatCode;
    result.storeOp = opcode == decodePkg::storeCode || opcode == decodePkg::storeFloatCode;
    result.jumpLink = opcode == decodePkg::jumpLinkCode;
    result.operandA = value1;
    result.operandB = (jumpForm || opcode[5]) ? immediate : value2;
    result.storeData = value2;
    result.linkAddress = pcValue + 32'd4;
    case (opcode)
        decodePkg::jumpCode, decodePkg::jumpLinkCode: begin
            result.jumpTaken = 1'b1;
            result.jumpTarget = pcValue + immediate;
        end
        decodePkg::branchZeroCode, decodePkg::branchNotZeroCode: begin
            result.jumpTaken = (value1 == 32'd0) == (opcode == decodePkg::branchZeroCode);
            result.jumpTarget = pcValue + immediate;
        end
        decodePkg::jumpRegisterCode: begin
            result.jumpTaken = 1'b1;
            result.jumpTarget = value1;
        end
        default: begin
            result.jumpTaken = 1'b0;
            result.jumpTarget = 32'd0;
        end
    endcase
    return result;
endfunction

`endif

/* tb/decodeStageTb.sv */
`timescale 1ns/10ps
`default_nettype none

module decodeStageTb;

    logic Clock;
    logic reset;
    logic [31:0] instruction;
    logic decodeEnable;
    logic [31:0] pc;
    logic writeEnable;
    decodePkg::registerNumber writeRegister;
    logic [31:0] writeData;
    logic [31:0] operandA;
    logic [31:0] operandB;
    logic [31:0] storeData;
    logic [31:0] linkAddress;
    logic jumpTaken;
    logic [31:0] jumpTarget;
    decodePkg::registerNumber destinationRegister;
    logic [5:0] functionCode;
    logic loadOp;
    logic storeOp;
    logic jumpLink;

    `include "decodeModel.svh"

    logic [31:0] shadow [64];
    logic [31:0] sentInstruction;
    stageOutputs expected;
    int strobeCount;
    int checksDone;
    int compareErrors;
    int stimulusErrors;
    int testsRun;
    int testsFailed;
    int testStartErrors;

    decodeStage decodeStage_i (.*);

    initial begin
        Clock = 1'b0;
        forever begin
            #2 Clock = ~Clock;
        end
    end

    function automatic int mismatch(input string name, input logic [31:0] want,
                                    input logic [31:0] got);
        if (got !== want) begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, want, got);
            return 1;
        end
        return 0;
    endfunction

    // Outputs are sampled one cycle after each strobe
    always @(negedge Clock) begin
        if (strobeCount != checksDone) begin
            expected = decodeModel(sentInstruction, pc, shadow);
            compareErrors += mismatch("operandA", expected.operandA, operandA);
            compareErrors += mismatch("operandB", expected.operandB, operandB);
            compareErrors += mismatch("storeData", expected.storeData, storeData);
            compareErrors += mismatch("linkAddress", expected.linkAddress, linkAddress);
            compareErrors += mismatch("jumpTaken", 32'(expected.jumpTaken), 32'(jumpTaken));
            compareErrors += mismatch("jumpTarget", expected.jumpTarget, jumpTarget);
            compareErrors += mismatch("destinationRegister", 32'(expected.destinationRegister),
                                      32'(destinationRegister));
            compareErrors += mismatch("functionCode", 32'(expected.functionCode),
                                      32'(functionCode));
            compareErrors += mismatch("loadOp", 32'(expected.loadOp), 32'(loadOp));
            compareErrors += mismatch("storeOp", 32'(expected.storeOp), 32'(storeOp));
            compareErrors += mismatch("jumpLink", 32'(expected.jumpLink), 32'(jumpLink));
            checksDone = checksDone + 1;
        end
    end

    function automatic int errorTotal();
        return compareErrors + stimulusErrors;
    endfunction

    task automatic finishTest(input string name);
        testsRun++;
        if (errorTotal() == testStartErrors) begin
            $display("Test %s: passed", name);
        end else begin
            testsFailed++;
            $display("Test %s: failed with %0d errors", name, errorTotal() - testStartErrors);
        end
        testStartErrors = errorTotal();
    endtask

    task automatic writeBack(input decodePkg::registerNumber target, input logic [31:0] value);
        @(negedge Clock);
        writeEnable <= 1'b1;
        writeRegister <= target;
        writeData <= value;
        if (target != 6'd0) begin
            shadow[target] <= value;
        end
        @(negedge Clock);
        writeEnable <= 1'b0;
    endtask

    // One strobe with an optional writeback in the same cycle
    task automatic strobeDecode(input logic [31:0] word, input logic [31:0] pcValue,
                                input logic doWrite, input decodePkg::registerNumber target,
                                input logic [31:0] value);
        int waitTarget;
        int cycles;
        waitTarget = strobeCount + 1;
        cycles = 0;
        @(negedge Clock);
        instruction <= word;
        decodeEnable <= 1'b1;
        pc <= pcValue;
        sentInstruction <= word;
        writeEnable <= doWrite;
        writeRegister <= target;
        writeData <= value;
        if (doWrite && target != 6'd0) begin
            shadow[target] <= value;
        end
        strobeCount <= strobeCount + 1;
        @(negedge Clock);
        decodeEnable <= 1'b0;
        writeEnable <= 1'b0;
        while (checksDone < waitTarget && cycles < 20) begin
            @(posedge Clock);
            cycles++;
        end
        if (checksDone < waitTarget) begin
            $display("Timeout: no comparison for the decode strobed before %0t", $time);
            stimulusErrors++;
        end
    endtask

    task automatic decodeOnly(input logic [31:0] word, input logic [31:0] pcValue);
        strobeDecode(word, pcValue, 1'b0, 6'd0, 32'd0);
    endtask

    function automatic logic [31:0] registerInstruction(input logic [5:0] opcode,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
            input logic [5:0] func);
        return {opcode, rd, rs1, rs2, 5'd0, func};
    endfunction

    function automatic logic [31:0] immediateInstruction(input logic [5:0] opcode,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [15:0] imm);
        return {opcode, rd, rs1, imm};
    endfunction

    initial begin
        logic [31:0] r;
        void'($urandom(32'h9a3a_4566));
        reset <= 1'b1;
        // A strobe held during reset must not load
        instruction <= immediateInstruction(decodePkg::jumpLinkCode, 5'd31, 5'd0, 16'h0100);
        decodeEnable <= 1'b1;
        pc <= 32'd0;
        writeEnable <= 1'b0;
        writeRegister <= 6'd0;
        writeData <= 32'd0;
        shadow[0] <= 32'd0;
        repeat (10) @(negedge Clock);
        reset <= 1'b0;
        decodeEnable <= 1'b0;
        instruction <= 32'd0;
        @(negedge Clock);
        stimulusErrors += mismatch("jumpTaken", 32'd0, 32'(jumpTaken));
        stimulusErrors += mismatch("loadOp", 32'd0, 32'(loadOp));
        stimulusErrors += mismatch("storeOp", 32'd0, 32'(storeOp));
        stimulusErrors += mismatch("jumpLink", 32'd0, 32'(jumpLink));
        stimulusErrors += mismatch("destinationRegister", 32'd0, 32'(destinationRegister));
        finishTest("reset state");

        for (int i = 1; i < 64; i++) begin
            writeBack(6'(i), $urandom());
        end
        // Integer register 0 must ignore this
        writeBack(6'd0, 32'hdead_beef);
        for (int i = 0; i < 16; i++) begin
            r = $urandom();
            decodeOnly(registerInstruction({2'b00, r[3:0]}, r[8:4], r[13:9], r[18:14],
                       {r[22:19], ((i < 8) ? {1'b0, r[23]} : 2'b10)}), $urandom());
        end
        decodeOnly(registerInstruction(6'b000001, 5'd3, 5'd0, 5'd0, 6'b000100), 32'h100);
        decodeOnly(registerInstruction(6'b000010, 5'd4, 5'd0, 5'd0, 6'b000010), 32'h104);
        strobeDecode(registerInstruction(6'b000011, 5'd5, 5'd7, 5'd8, 6'b000000), 32'h200,
                     1'b1, 6'd7, 32'h1357_9bdf);
        // Write lands before the clock edge while the add is still latched
        @(negedge Clock);
        writeEnable <= 1'b1;
        writeRegister <= 6'd7;
        writeData <= 32'h2468_ace0;
        shadow[7] <= 32'h2468_ace0;
        #1;
        stimulusErrors += mismatch("operandA", 32'h2468_ace0, operandA);
        @(negedge Clock);
        writeEnable <= 1'b0;
        finishTest("register file");

        decodeOnly(immediateInstruction(6'b100011, 5'd2, 5'd3, 16'h8001), 32'h400);
        decodeOnly(immediateInstruction(6'b101000, 5'd2, 5'd3, 16'h7fff), 32'h404);
        decodeOnly(immediateInstruction(decodePkg::addUpperCode, 5'd6, 5'd0, 16'hbeef), 32'h408);
        decodeOnly({decodePkg::jumpCode, 26'h3ff_fff0}, 32'h40c);
        decodeOnly({6'b010101, 26'h012_3456}, 32'h410);
        for (int i = 0; i < 10; i++) begin
            r = $urandom();
            decodeOnly(immediateInstruction({2'b10, r[3:0]}, r[8:4], r[13:9], r[31:16]),
                       $urandom());
        end
        finishTest("immediates");

        for (int i = 0; i < 8; i++) begin
            r = $urandom();
            decodeOnly(immediateInstruction(decodePkg::loadCode + 6'(i % 4), r[4:0], r[9:5],
                       r[31:16]), $urandom());
        end
        decodeOnly(registerInstruction(6'b000000, 5'd12, 5'd13, 5'd0, decodePkg::intToFloat),
                   32'h600);
        decodeOnly(registerInstruction(6'b000000, 5'd14, 5'd15, 5'd0,
                   decodePkg::unsignedToFloat), 32'h604);
        finishTest("loads, stores and conversions");

        writeBack(6'd9, 32'd0);
        writeBack(6'd10, 32'h0000_1234);
        decodeOnly(immediateInstruction(decodePkg::branchZeroCode, 5'd0, 5'd9, 16'hfff0), 32'h800);
        decodeOnly(immediateInstruction(decodePkg::branchZeroCode, 5'd0, 5'd10, 16'h0020), 32'h804);
        decodeOnly(immediateInstruction(decodePkg::branchNotZeroCode, 5'd0, 5'd9, 16'h0040),
                   32'h808);
        decodeOnly(immediateInstruction(decodePkg::branchNotZeroCode, 5'd0, 5'd10, 16'hff00),
                   32'h80c);
        decodeOnly(immediateInstruction(decodePkg::jumpRegisterCode, 5'd0, 5'd10, 16'd0), 32'h810);
        decodeOnly({decodePkg::jumpCode, 26'h000_0040}, 32'h814);
        decodeOnly(immediateInstruction(decodePkg::jumpLinkCode, 5'd31, 5'd0, 16'h0100), 32'h818);
        finishTest("jumps");

        for (int i = 0; i < 300; i++) begin
            r = $urandom();
            strobeDecode($urandom(), $urandom(), r[0], r[6:1], $urandom());
        end
        finishTest("random mix");

        if (strobeCount != checksDone) begin
            $display("Only %0d of %0d decodes were compared", checksDone, strobeCount);
            stimulusErrors++;
        end
        $display("Tests run %0d, failed %0d, decodes compared %0d, errors %0d",
                 testsRun, testsFailed, checksDone, errorTotal());
        if (errorTotal() == 0 && testsFailed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+tb
verilog/decodePkg.sv
verilog/instructionDecoder.sv
verilog/registerFile.sv
verilog/operandUnit.sv
verilog/decodeStage.sv
tb/decodeStageTb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the decode stage testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --timescale 1ns/10ps -f vlog.f \
		--top-module decodeStageTb -Mdir obj_dir -o decodeStageTbSim
	./obj_dir/decodeStageTbSim | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
